// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

  // --------------------
  // cache geometry
  // --------------------
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int SET_NUM    = 16;

  localparam int OFFSET_W = $clog2(LINE_WORDS);
  localparam int INDEX_W  = $clog2(SET_NUM);
  // two low bits are the byte position inside a word
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W - 2;

  // --------------------
  // types
  // --------------------
  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [INDEX_W-1:0]           index_t;
  typedef logic [OFFSET_W-1:0]          offset_t;
  typedef logic [TAG_W-1:0]             tag_t;
  // word 0 sits in the low bits
  typedef logic [LINE_WORDS*WORD_W-1:0] line_t;
  typedef logic [1:0]                   resp_t;

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data,
    st_fill
  } refill_state_t;

endpackage

`default_nettype wire

// File: rtl/icache_tag_store.sv
`default_nettype none

module icache_tag_store
  import icache_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   flush,
  input  logic   fetch_valid,
  input  addr_t  fetch_pc,
  input  logic   fill_en,
  input  logic   fill_ok,
  input  index_t fill_index,
  input  tag_t   fill_tag,
  output logic   hit,
  output index_t index,
  output offset_t offset,
  output tag_t   tag
);

  tag_t               tag_mem [SET_NUM];
  logic [SET_NUM-1:0] valid;

  // --------------------
  // pc split
  // --------------------
  assign offset = fetch_pc[2 +: OFFSET_W];
  assign index  = fetch_pc[OFFSET_W+2 +: INDEX_W];
  assign tag    = fetch_pc[ADDR_W-1 -: TAG_W];

  assign hit = fetch_valid && valid[index] && (tag_mem[index] == tag);

  // --------------------
  // valid bits
  // --------------------
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      valid <= '0;
    end else if (fill_en) begin
      // a failed burst leaves the set invalid
      valid[fill_index] <= fill_ok;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_en) begin
      tag_mem[fill_index] <= fill_tag;
    end
  end

  // flush is only legal between fetches
  a_flush_idle : assert property (
    @(posedge clock) disable iff (reset)
    !(flush && fetch_valid)
  ) else $error("flush pulsed while a fetch is pending");

endmodule

`default_nettype wire

// File: rtl/icache_data_store.sv
`default_nettype none

module icache_data_store
  import icache_pkg::*;
(
  input  logic    clock,
  input  index_t  index,
  input  offset_t offset,
  input  logic    fill_en,
  input  index_t  fill_index,
  input  line_t   fill_line,
  output word_t   rd_data
);

  // one line per set
  line_t line_mem [SET_NUM];
  line_t rd_line;

  // --------------------
  // read side
  // --------------------
  assign rd_line = line_mem[index];

  // word at the pc offset, word 0 in the low bits
  assign rd_data = rd_line[offset*WORD_W +: WORD_W];

  // --------------------
  // fill side
  // --------------------
  always_ff @(posedge clock) begin
    if (fill_en) begin
      line_mem[fill_index] <= fill_line;
    end
  end

endmodule

`default_nettype wire

// File: rtl/icache_refill.sv
`default_nettype none

module icache_refill
  import icache_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   fetch_valid,
  input  addr_t  fetch_pc,
  input  logic   hit,
  output logic   ar_valid,
  input  logic   ar_ready,
  output addr_t  ar_addr,
  input  logic   r_valid,
  output logic   r_ready,
  input  word_t  r_data,
  input  resp_t  r_resp,
  input  logic   r_last,
  output logic   fill_en,
  output logic   fill_ok,
  output index_t fill_index,
  output tag_t   fill_tag,
  output line_t  fill_line,
  output word_t  fill_word,
  output logic   busy
);

  refill_state_t           state;
  refill_state_t           state_next;
  logic                    miss;
  logic                    ar_fire;
  logic                    r_fire;
  addr_t                   req_pc;
  offset_t                 req_offset;
  logic [LINE_WORDS-1:0]   wr_ptr;
  line_t                   line_buf;
  logic                    burst_err;

  assign miss    = fetch_valid && !hit;
  assign ar_fire = ar_valid && ar_ready;
  assign r_fire  = r_valid && r_ready;

  // --------------------
  // state machine
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (miss) state_next = st_addr;
      st_addr: if (ar_fire) state_next = st_data;
      st_data: if (r_fire && r_last) state_next = st_fill;
      st_fill: state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  // both handshake signals come straight from the state register
  assign ar_valid = (state == st_addr);
  assign r_ready  = (state == st_data);
  assign busy     = (state != st_idle);

  // --------------------
  // request capture
  // --------------------
  always_ff @(posedge clock) begin
    if (state == st_idle && miss) begin
      req_pc <= fetch_pc;
    end
  end

  assign ar_addr    = {req_pc[ADDR_W-1:OFFSET_W+2], {(OFFSET_W+2){1'b0}}};
  assign req_offset = req_pc[2 +: OFFSET_W];
  assign fill_index = req_pc[OFFSET_W+2 +: INDEX_W];
  assign fill_tag   = req_pc[ADDR_W-1 -: TAG_W];

  // --------------------
  // line buffer
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr    <= '0;
      burst_err <= 1'b0;
    end else if (state == st_idle && miss) begin
      wr_ptr    <= {{(LINE_WORDS-1){1'b0}}, 1'b1};
      burst_err <= 1'b0;
    end else if (r_fire) begin
      wr_ptr    <= {wr_ptr[LINE_WORDS-2:0], wr_ptr[LINE_WORDS-1]};
      // sticky so that any bad beat spoils the line
      burst_err <= burst_err || (r_resp != 2'b00);
    end
  end

  always_ff @(posedge clock) begin
    if (r_fire) begin
      for (int i = 0; i < LINE_WORDS; i++) begin
        if (wr_ptr[i]) begin
          line_buf[i*WORD_W +: WORD_W] <= r_data;
        end
      end
    end
  end

  // --------------------
  // fill cycle
  // --------------------
  assign fill_en   = (state == st_fill);
  assign fill_ok   = !burst_err;
  assign fill_line = line_buf;
  assign fill_word = line_buf[req_offset*WORD_W +: WORD_W];

  a_ar_addr_hold : assert property (
    @(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> $stable(ar_addr)
  ) else $error("ar_addr changed before the AR handshake");

  // only one burst is outstanding, so the bus offers beats only in st_data
  a_r_beat_state : assert property (
    @(posedge clock) disable iff (reset)
    r_valid |-> state == st_data
  ) else $error("R beat offered outside st_data");

  // the fetch side must hold its request through the whole refill
  a_pc_hold : assert property (
    @(posedge clock) disable iff (reset)
    busy |-> fetch_valid && fetch_pc == req_pc
  ) else $error("fetch_pc not held during refill");

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
`default_nettype none

module icache_top
  import icache_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  flush,
  input  logic  fetch_valid,
  input  addr_t fetch_pc,
  output logic  fetch_ready,
  output word_t fetch_data,
  output logic  fetch_error,
  output logic  ar_valid,
  input  logic  ar_ready,
  output addr_t ar_addr,
  input  logic  r_valid,
  output logic  r_ready,
  input  word_t r_data,
  input  resp_t r_resp,
  input  logic  r_last
);

  logic    hit;
  index_t  index;
  offset_t offset;
  tag_t    tag;
  word_t   rd_data;
  logic    fill_en;
  logic    fill_ok;
  index_t  fill_index;
  tag_t    fill_tag;
  line_t   fill_line;
  word_t   fill_word;
  logic    busy;

  icache_tag_store u_tag_store (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fill_en     (fill_en),
    .fill_ok     (fill_ok),
    .fill_index  (fill_index),
    .fill_tag    (fill_tag),
    .hit         (hit),
    .index       (index),
    .offset      (offset),
    .tag         (tag)
  );

  icache_data_store u_data_store (
    .clock      (clock),
    .index      (index),
    .offset     (offset),
    .fill_en    (fill_en),
    .fill_index (fill_index),
    .fill_line  (fill_line),
    .rd_data    (rd_data)
  );

  icache_refill u_refill (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .hit         (hit),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .ar_addr     (ar_addr),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .r_data      (r_data),
    .r_resp      (r_resp),
    .r_last      (r_last),
    .fill_en     (fill_en),
    .fill_ok     (fill_ok),
    .fill_index  (fill_index),
    .fill_tag    (fill_tag),
    .fill_line   (fill_line),
    .fill_word   (fill_word),
    .busy        (busy)
  );

  // --------------------
  // fetch answer
  // --------------------
  // hits are held off while a refill owns the port
  assign fetch_ready = (hit && !busy) || fill_en;
  assign fetch_data  = fill_en ? fill_word : rd_data;
  assign fetch_error = fill_en && !fill_ok;

  // the line being installed belongs to the pc still on the fetch port
  a_fill_matches_pc : assert property (
    @(posedge clock) disable iff (reset)
    fill_en |-> fill_index == index && fill_tag == tag
  ) else $error("fill target differs from the pending fetch");

endmodule

`default_nettype wire

// File: dv/axi_read_mem.sv
`default_nettype none

module axi_read_mem
  import icache_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   stall_en,
  input  logic   err_en,
  input  addr_t  err_line,
  input  logic   ar_valid,
  output logic   ar_ready,
  input  addr_t  ar_addr,
  output logic   r_valid,
  input  logic   r_ready,
  output word_t  r_data,
  output resp_t  r_resp,
  output logic   r_last,
  output int     ar_count
);

  logic    busy;
  addr_t   base;
  offset_t beat;
  logic    bad;
  addr_t   beat_addr;

  // one in three cycles is a gap while stalls are on
  function automatic logic stall_now();
    return stall_en && ($urandom % 3 == 0);
  endfunction

  // --------------------
  // burst control
  // --------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
      busy     <= 1'b0;
      base     <= '0;
      beat     <= '0;
      bad      <= 1'b0;
      ar_count <= 0;
    end else if (!busy) begin
      if (ar_valid && ar_ready) begin
        busy     <= 1'b1;
        base     <= ar_addr;
        beat     <= '0;
        bad      <= err_en && (ar_addr == err_line);
        ar_count <= ar_count + 1;
        ar_ready <= 1'b0;
        r_valid  <= !stall_now();
      end else begin
        ar_ready <= !stall_now();
      end
    end else if (r_valid && r_ready) begin
      if (r_last) begin
        busy     <= 1'b0;
        r_valid  <= 1'b0;
        ar_ready <= !stall_now();
      end else begin
        beat    <= beat + 1'b1;
        r_valid <= !stall_now();
      end
    end else if (!r_valid) begin
      r_valid <= !stall_now();
    end
  end

  // --------------------
  // beat contents
  // --------------------
  assign beat_addr = base | addr_t'({beat, 2'b00});
  assign r_data    = ~beat_addr ^ 32'h5A5A_0000;
  // every beat of the error line is SLVERR
  assign r_resp    = bad ? 2'b10 : 2'b00;
  assign r_last    = busy && (beat == offset_t'(LINE_WORDS - 1));

endmodule

`default_nettype wire

// File: dv/icache_tb.sv
`default_nettype none

module icache_tb
  import icache_pkg::*;
();

  localparam int    HALF       = 20;
  localparam int    SETTLE     = 10;
  // about 50 fetches, each well under a few hundred stalled cycles
  localparam int    MAX_CYCLES = 20000;
  localparam addr_t ERR_LINE   = 32'h0000_3A40;

  logic  clock;
  logic  reset;
  logic  flush;
  logic  fetch_valid;
  addr_t fetch_pc;
  logic  fetch_ready;
  word_t fetch_data;
  logic  fetch_error;
  logic  ar_valid;
  logic  ar_ready;
  addr_t ar_addr;
  logic  r_valid;
  logic  r_ready;
  word_t r_data;
  resp_t r_resp;
  logic  r_last;
  logic  stall_en;
  logic  err_en;
  int    ar_count;
  int    errors;
  int    tests_passed;
  int    tests_failed;
  int    cycles;

  icache_top dut (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_ready (fetch_ready),
    .fetch_data  (fetch_data),
    .fetch_error (fetch_error),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .ar_addr     (ar_addr),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .r_data      (r_data),
    .r_resp      (r_resp),
    .r_last      (r_last)
  );

  axi_read_mem u_mem (
    .clock    (clock),
    .reset    (reset),
    .stall_en (stall_en),
    .err_en   (err_en),
    .err_line (ERR_LINE),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar_addr  (ar_addr),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r_data   (r_data),
    .r_resp   (r_resp),
    .r_last   (r_last),
    .ar_count (ar_count)
  );

  initial begin
    clock = 1'b0;
    forever #HALF clock = ~clock;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // --------------------
  // compare tasks
  // --------------------
  function automatic word_t expected_word(input addr_t a);
    return ~a ^ 32'h5A5A_0000;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: passed", name);
      tests_passed++;
    end else begin
      $display("test %s: failed", name);
      tests_failed++;
    end
  endtask

  // --------------------
  // fetch port
  // --------------------
  // waits counts the cycles between fetch_valid and fetch_ready
  task automatic fetch_word(input addr_t pc, output word_t data, output logic err,
                            output int waits);
    @(negedge clock);
    fetch_valid = 1'b1;
    fetch_pc    = pc;
    waits       = 0;
    #SETTLE;
    while (!fetch_ready) begin
      @(negedge clock);
      #SETTLE;
      waits++;
    end
    data = fetch_data;
    err  = fetch_error;
    @(negedge clock);
    fetch_valid = 1'b0;
  endtask

  task automatic fetch_and_compare(input addr_t pc, input logic expect_hit);
    word_t data;
    logic  err;
    int    waits;
    fetch_word(pc, data, err, waits);
    check_word("fetch_data", data, expected_word(pc));
    check_flag("fetch_error", err, 1'b0);
    if (expect_hit) begin
      check_flag("fetch_ready with fetch_valid", waits == 0, 1'b1);
    end
  endtask

  task automatic pulse_flush();
    @(negedge clock);
    flush = 1'b1;
    @(negedge clock);
    flush = 1'b0;
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic cold_miss();
    int e0;
    int n0;
    e0 = errors;
    n0 = ar_count;
    fetch_and_compare(32'h0000_1008, 1'b0);
    check_count("ar_count", ar_count, n0 + 1);
    report_test("cold miss", e0);
  endtask

  task automatic hit_after_fill();
    int e0;
    int n0;
    e0 = errors;
    n0 = ar_count;
    fetch_and_compare(32'h0000_1008, 1'b1);
    fetch_and_compare(32'h0000_1000, 1'b1);
    fetch_and_compare(32'h0000_1004, 1'b1);
    fetch_and_compare(32'h0000_100C, 1'b1);
    check_count("ar_count", ar_count, n0);
    report_test("hit after fill", e0);
  endtask

  task automatic full_lines_with_stalls();
    int    e0;
    int    n0;
    int    ord [4];
    int    j;
    int    tmp;
    addr_t base;
    e0       = errors;
    stall_en = 1'b1;
    for (int line = 0; line < 8; line++) begin
      base = 32'h0000_2000 + addr_t'(line * 16);
      for (int i = 0; i < 4; i++) begin
        ord[i] = i;
      end
      for (int i = 3; i > 0; i--) begin
        j      = int'($urandom % (i + 1));
        tmp    = ord[i];
        ord[i] = ord[j];
        ord[j] = tmp;
      end
      n0 = ar_count;
      for (int i = 0; i < 4; i++) begin
        fetch_and_compare(base + addr_t'(ord[i] * 4), 1'b0);
      end
      // one burst per line
      check_count("ar_count", ar_count, n0 + 1);
    end
    report_test("whole lines with stalls", e0);
  endtask

  task automatic conflict_replace();
    int e0;
    int n0;
    e0 = errors;
    n0 = ar_count;
    // same index 2, tags differ
    fetch_and_compare(32'h0000_4020, 1'b0);
    fetch_and_compare(32'h0000_8024, 1'b0);
    fetch_and_compare(32'h0000_4020, 1'b0);
    check_count("ar_count", ar_count, n0 + 3);
    report_test("conflict replacement", e0);
  endtask

  task automatic flush_refetch();
    int e0;
    int n0;
    e0 = errors;
    n0 = ar_count;
    fetch_and_compare(32'h0000_5034, 1'b0);
    fetch_and_compare(32'h0000_5034, 1'b1);
    check_count("ar_count", ar_count, n0 + 1);
    pulse_flush();
    fetch_and_compare(32'h0000_5034, 1'b0);
    check_count("ar_count", ar_count, n0 + 2);
    report_test("flush", e0);
  endtask

  task automatic error_response();
    int    e0;
    int    n0;
    word_t data;
    logic  err;
    int    waits;
    e0     = errors;
    n0     = ar_count;
    err_en = 1'b1;
    fetch_word(ERR_LINE + 32'h8, data, err, waits);
    check_flag("fetch_error", err, 1'b1);
    check_count("ar_count", ar_count, n0 + 1);
    // line was not installed, so this misses again
    fetch_word(ERR_LINE + 32'h8, data, err, waits);
    check_flag("fetch_error", err, 1'b1);
    check_count("ar_count", ar_count, n0 + 2);
    err_en = 1'b0;
    fetch_and_compare(ERR_LINE + 32'h8, 1'b0);
    check_count("ar_count", ar_count, n0 + 3);
    report_test("error response", e0);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    reset        = 1'b1;
    flush        = 1'b0;
    fetch_valid  = 1'b0;
    fetch_pc     = '0;
    stall_en     = 1'b0;
    err_en       = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(58));
    repeat (5) @(negedge clock);
    reset = 1'b0;

    cold_miss();
    hit_after_fill();
    full_lines_with_stalls();
    conflict_replace();
    flush_refetch();
    error_response();

    $display("tests passed %0d failed %0d, checks failed %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/icache_pkg.sv
rtl/icache_tag_store.sv
rtl/icache_data_store.sv
rtl/icache_refill.sv
rtl/icache_top.sv
dv/axi_read_mem.sv
dv/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module icache_tb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vicache_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
